/* hw/iob_apb_pkg.sv */
`default_nettype none

package iob_apb_pkg;

   // Bus widths
   localparam int ADDR_W = 12;  // Byte address
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;  // One strobe per byte

   // Peripheral select field in the byte address
   localparam int SLV_SEL_HI = 11;
   localparam int SLV_SEL_LO = 10;
   localparam int SLV_SEL_W  = SLV_SEL_HI - SLV_SEL_LO + 1;

   localparam logic [SLV_SEL_W-1:0] SLV_REGFILE = 2'd0;  // 0x000 - 0x3FF
   localparam logic [SLV_SEL_W-1:0] SLV_TIMER   = 2'd1;  // 0x400 - 0x7FF

   // Register bank
   localparam int RF_DEPTH = 8;
   localparam int RF_IDX_W = $clog2(RF_DEPTH);  // Word index from address bits 4..2

   // Timer register map, byte offsets within its window
   localparam int TMR_OFS_W = 4;
   localparam logic [TMR_OFS_W-1:0] TMR_CTRL_OFS  = 4'h0;
   localparam logic [TMR_OFS_W-1:0] TMR_COUNT_OFS = 4'h4;
   localparam logic [TMR_OFS_W-1:0] TMR_CMP_OFS   = 4'h8;
   localparam logic [TMR_OFS_W-1:0] TMR_STAT_OFS  = 4'hC;

   // Control register bits
   localparam int TMR_CTRL_EN_BIT    = 0;  // Count enable
   localparam int TMR_CTRL_IRQEN_BIT = 1;  // Interrupt enable

   // Timer access latency
   localparam int TMR_WAIT   = 1;  // Wait states per access
   localparam int TMR_WAIT_W = $clog2(TMR_WAIT + 1);

endpackage

`default_nettype wire

/* hw/apb_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface apb_if import iob_apb_pkg::*; ();

   logic [ADDR_W-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [DATA_W-1:0] pwdata;
   logic [STRB_W-1:0] pstrb;
   logic [DATA_W-1:0] prdata;
   logic              pready;

   // Requester side
   modport master (
      output paddr,
      output psel,
      output penable,
      output pwrite,
      output pwdata,
      output pstrb,
      input  prdata,
      input  pready
   );

   // Completer side
   modport slave (
      input  paddr,
      input  psel,
      input  penable,
      input  pwrite,
      input  pwdata,
      input  pstrb,
      output prdata,
      output pready
   );

endinterface

`default_nettype wire

/* hw/iob2apb.sv */
`timescale 1ns/100ps
`default_nettype none

module iob2apb import iob_apb_pkg::*; (
   input  logic              clk_i,
   input  logic              reset_i,
   // IOb slave side
   input  logic              iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [DATA_W-1:0] iob_wdata_i,
   input  logic [STRB_W-1:0] iob_wstrb_i,
   output logic              iob_rvalid_o,
   output logic [DATA_W-1:0] iob_rdata_o,
   output logic              iob_ready_o,
   // APB master side
   apb_if.master             apb
);

   typedef enum logic {
      ST_IDLE,
      ST_XFER
   } state_t;

   state_t state_q;
   state_t state_nxt;

   // Next values of the registered outputs
   logic              sel_nxt;
   logic              enable_nxt;
   logic              write_nxt;
   logic              ready_nxt;
   logic              rvalid_nxt;
   logic [ADDR_W-1:0] addr_nxt;
   logic [DATA_W-1:0] wdata_nxt;
   logic [STRB_W-1:0] strb_nxt;
   logic [DATA_W-1:0] rdata_nxt;

   logic accept;  // Request taken this edge
   logic done;    // APB access phase completes this edge

   assign accept = iob_avalid_i & iob_ready_o;
   assign done   = apb.penable & apb.pready;

   always_comb begin
      // Hold everything by default, rvalid is a pulse
      state_nxt  = state_q;
      sel_nxt    = apb.psel;
      enable_nxt = apb.penable;
      write_nxt  = apb.pwrite;
      ready_nxt  = iob_ready_o;
      rvalid_nxt = 1'b0;
      addr_nxt   = apb.paddr;
      wdata_nxt  = apb.pwdata;
      strb_nxt   = apb.pstrb;
      rdata_nxt  = iob_rdata_o;

      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               addr_nxt  = iob_addr_i;
               wdata_nxt = iob_wdata_i;
               strb_nxt  = iob_wstrb_i;
               write_nxt = |iob_wstrb_i;  // Any strobe bit makes it a write
               sel_nxt   = 1'b1;          // Setup phase starts
               ready_nxt = 1'b0;
               state_nxt = ST_XFER;
            end
         end
         ST_XFER: begin
            enable_nxt = 1'b1;
            // Ready is only looked at once penable is up
            if (done) begin
               rdata_nxt  = apb.prdata;
               rvalid_nxt = 1'b1;
               ready_nxt  = 1'b1;
               sel_nxt    = 1'b0;
               enable_nxt = 1'b0;
               state_nxt  = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   // Control registers
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q      <= ST_IDLE;
         apb.psel     <= 1'b0;
         apb.penable  <= 1'b0;
         apb.pwrite   <= 1'b0;
         iob_ready_o  <= 1'b1;  // Ready for a request out of reset
         iob_rvalid_o <= 1'b0;
      end else begin
         state_q      <= state_nxt;
         apb.psel     <= sel_nxt;
         apb.penable  <= enable_nxt;
         apb.pwrite   <= write_nxt;
         iob_ready_o  <= ready_nxt;
         iob_rvalid_o <= rvalid_nxt;
      end
   end

   // Payload registers
   always_ff @(posedge clk_i) begin
      apb.paddr   <= addr_nxt;
      apb.pwdata  <= wdata_nxt;
      apb.pstrb   <= strb_nxt;
      iob_rdata_o <= rdata_nxt;
   end

endmodule

`default_nettype wire

/* hw/apb_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_decoder import iob_apb_pkg::*; (
   apb_if.slave  up,   // From the bridge
   apb_if.master rf,   // To the register bank
   apb_if.master tmr   // To the timer
);

   logic [SLV_SEL_W-1:0] sel;

   assign sel = up.paddr[SLV_SEL_HI:SLV_SEL_LO];

   // Register bank bus, psel gated by its window
   assign rf.paddr   = up.paddr;
   assign rf.psel    = up.psel & (sel == SLV_REGFILE);
   assign rf.penable = up.penable;
   assign rf.pwrite  = up.pwrite;
   assign rf.pwdata  = up.pwdata;
   assign rf.pstrb   = up.pstrb;

   // Timer bus
   assign tmr.paddr   = up.paddr;
   assign tmr.psel    = up.psel & (sel == SLV_TIMER);
   assign tmr.penable = up.penable;
   assign tmr.pwrite  = up.pwrite;
   assign tmr.pwdata  = up.pwdata;
   assign tmr.pstrb   = up.pstrb;

   // Response mux
   always_comb begin
      case (sel)
         SLV_REGFILE: begin
            up.prdata = rf.prdata;
            up.pready = rf.pready;
         end
         SLV_TIMER: begin
            up.prdata = tmr.prdata;
            up.pready = tmr.pready;
         end
         default: begin
            // Hole in the map, finish at once with zero data
            up.prdata = '0;
            up.pready = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hw/apb_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_regfile import iob_apb_pkg::*; (
   input  logic  clk_i,
   input  logic  reset_i,
   apb_if.slave  apb
);

   logic [DATA_W-1:0]   regs [RF_DEPTH];
   logic [RF_IDX_W-1:0] idx;
   logic                wr_en;

   // Word index, upper address bits alias the same bank
   assign idx = apb.paddr[RF_IDX_W+1:2];

   // No wait states, every access phase is the completing one
   assign wr_en = apb.psel & apb.penable & apb.pwrite;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < RF_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (apb.pstrb[b]) begin
               regs[idx][8*b +: 8] <= apb.pwdata[8*b +: 8];  // Byte lane b
            end
         end
      end
   end

   // Writes return zero
   assign apb.prdata = apb.pwrite ? '0 : regs[idx];
   assign apb.pready = 1'b1;

endmodule

`default_nettype wire

/* hw/apb_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_timer import iob_apb_pkg::*; (
   input  logic  clk_i,
   input  logic  reset_i,
   apb_if.slave  apb,
   output logic  irq_o
);

   logic [1:0]            ctrl_q;   // Enable and interrupt enable
   logic [DATA_W-1:0]     count_q;
   logic [DATA_W-1:0]     cmp_q;
   logic                  flag_q;   // Sticky compare match
   logic [TMR_WAIT_W-1:0] wait_q;   // Access cycles already stalled
   logic [TMR_OFS_W-1:0]  ofs;
   logic                  access;
   logic                  wr_en;
   logic                  match;

   assign ofs    = {apb.paddr[TMR_OFS_W-1:2], 2'b00};
   assign access = apb.psel & apb.penable;
   assign wr_en  = access & apb.pready & apb.pwrite;  // Strobes are ignored
   assign match  = ctrl_q[TMR_CTRL_EN_BIT] & (count_q == cmp_q);

   // Wait-state generator, pready goes high after TMR_WAIT access cycles
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         apb.pready <= 1'b0;
         wait_q     <= '0;
      end else if (access && apb.pready) begin
         apb.pready <= 1'b0;  // Transfer ends on this edge
         wait_q     <= '0;
      end else if (access) begin
         if (wait_q == TMR_WAIT_W'(TMR_WAIT - 1)) begin
            apb.pready <= 1'b1;
         end else begin
            wait_q <= wait_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_q  <= '0;
         count_q <= '0;
         cmp_q   <= '0;
         flag_q  <= 1'b0;
         irq_o   <= 1'b0;
      end else begin
         if (wr_en && ofs == TMR_CTRL_OFS) ctrl_q <= apb.pwdata[1:0];
         if (wr_en && ofs == TMR_CMP_OFS) cmp_q <= apb.pwdata;

         // A load beats the increment
         if (wr_en && ofs == TMR_COUNT_OFS) begin
            count_q <= apb.pwdata;
         end else if (ctrl_q[TMR_CTRL_EN_BIT]) begin
            count_q <= count_q + 1'b1;
         end

         // Write one to clear, a new match wins
         if (match) begin
            flag_q <= 1'b1;
         end else if (wr_en && ofs == TMR_STAT_OFS && apb.pwdata[0]) begin
            flag_q <= 1'b0;
         end

         irq_o <= flag_q & ctrl_q[TMR_CTRL_IRQEN_BIT];
      end
   end

   // Read mux
   always_comb begin
      case (ofs)
         TMR_CTRL_OFS:  apb.prdata = {{(DATA_W-2){1'b0}}, ctrl_q};
         TMR_COUNT_OFS: apb.prdata = count_q;
         TMR_CMP_OFS:   apb.prdata = cmp_q;
         TMR_STAT_OFS:  apb.prdata = {{(DATA_W-1){1'b0}}, flag_q};
         default:       apb.prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/iob_apb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module iob_apb_top import iob_apb_pkg::*; (
   input  logic              clk_i,
   input  logic              reset_i,
   // IOb host port
   input  logic              iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [DATA_W-1:0] iob_wdata_i,
   input  logic [STRB_W-1:0] iob_wstrb_i,
   output logic              iob_rvalid_o,
   output logic [DATA_W-1:0] iob_rdata_o,
   output logic              iob_ready_o,
   output logic              irq_o         // Timer interrupt
);

   apb_if apb_up ();   // Bridge to decoder
   apb_if apb_rf ();   // Decoder to register bank
   apb_if apb_tmr ();  // Decoder to timer

   iob2apb u_bridge (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .iob_avalid_i(iob_avalid_i),
      .iob_addr_i  (iob_addr_i),
      .iob_wdata_i (iob_wdata_i),
      .iob_wstrb_i (iob_wstrb_i),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o),
      .iob_ready_o (iob_ready_o),
      .apb         (apb_up.master)
   );

   apb_decoder u_decoder (
      .up (apb_up.slave),
      .rf (apb_rf.master),
      .tmr(apb_tmr.master)
   );

   apb_regfile u_regfile (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .apb    (apb_rf.slave)
   );

   apb_timer u_timer (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .apb    (apb_tmr.slave),
      .irq_o  (irq_o)
   );

endmodule

`default_nettype wire

/* sim/iob_apb_props.sv */
`timescale 1ns/100ps
`default_nettype none

module iob_apb_props import iob_apb_pkg::*; (
   input logic              clk_i,
   input logic              reset_i,
   input logic              psel_i,
   input logic              penable_i,
   input logic              pready_i,
   input logic [ADDR_W-1:0] paddr_i,
   input logic              rvalid_i,
   input logic              ready_i
);

   // Select and address held until the access phase completes
   assert property (@(posedge clk_i) disable iff (reset_i)
      psel_i && !(penable_i && pready_i) |=> psel_i && $stable(paddr_i))
      else $error("APB psel or paddr changed before completion");

   assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(penable_i) |-> $past(psel_i))
      else $error("APB penable rose without a setup cycle");

   assert property (@(posedge clk_i) disable iff (reset_i)
      psel_i && !penable_i |=> penable_i)
      else $error("APB setup cycle not followed by access");

   assert property (@(posedge clk_i) disable iff (reset_i) rvalid_i |=> !rvalid_i)
      else $error("IOb rvalid longer than one cycle");

   assert property (@(posedge clk_i) disable iff (reset_i) psel_i |-> !ready_i)
      else $error("IOb ready high during an APB transfer");

endmodule

bind iob2apb iob_apb_props u_props (
   .clk_i    (clk_i),
   .reset_i  (reset_i),
   .psel_i   (apb.psel),
   .penable_i(apb.penable),
   .pready_i (apb.pready),
   .paddr_i  (apb.paddr),
   .rvalid_i (iob_rvalid_o),
   .ready_i  (iob_ready_o)
);

`default_nettype wire

/* sim/tb_iob_apb.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_iob_apb import iob_apb_pkg::*; ();

   localparam int N_TESTS   = 6;
   localparam int WD_CYCLES = N_TESTS * 200;
   localparam logic [DATA_W-1:0] CTRL_EN    = 1 << TMR_CTRL_EN_BIT;
   localparam logic [DATA_W-1:0] CTRL_IRQEN = 1 << TMR_CTRL_IRQEN_BIT;

   logic              clk;
   logic              reset;
   logic              avalid;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   logic              rvalid;
   logic [DATA_W-1:0] rdata;
   logic              ready;
   logic              irq;
   logic [DATA_W-1:0] model [RF_DEPTH];  // Expected register bank contents
   integer            seed;
   bit                run_closed = 1'b0;  // Set once a final verdict is printed

   iob_apb_top dut_i (
      .clk_i       (clk),
      .reset_i     (reset),
      .iob_avalid_i(avalid),
      .iob_addr_i  (addr),
      .iob_wdata_i (wdata),
      .iob_wstrb_i (wstrb),
      .iob_rvalid_o(rvalid),
      .iob_rdata_o (rdata),
      .iob_ready_o (ready),
      .irq_o       (irq)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [ADDR_W-1:0] rf_addr(input int i);
      return ADDR_W'(i * 4);
   endfunction

   function automatic logic [ADDR_W-1:0] tmr_addr(input logic [TMR_OFS_W-1:0] ofs);
      return {SLV_TIMER, {(ADDR_W-SLV_SEL_W-TMR_OFS_W){1'b0}}, ofs};
   endfunction

   // Old word with the strobed byte lanes replaced
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      run_closed = 1'b1;
      $display("SIMULATION FAILED");
      $fatal(1, "Run aborted");
   endtask

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string name);
      if (actual !== expected) begin
         $display("FAIL at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, actual,
                  expected);
         run_closed = 1'b1;
         $display("SIMULATION FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // One request with its latency in cycles up to rvalid
   task automatic iob_access(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                             input logic [STRB_W-1:0] s, output logic [DATA_W-1:0] q,
                             output int lat);
      while (!ready) @(negedge clk);  // Host waits for the bridge
      avalid = 1'b1;
      addr   = a;
      wdata  = d;
      wstrb  = s;
      @(negedge clk);
      avalid = 1'b0;
      wstrb  = '0;
      lat    = 1;
      while (!rvalid) begin
         @(negedge clk);
         lat++;
      end
      q = rdata;
   endtask

   task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                            input logic [STRB_W-1:0] s, input int exp_lat);
      logic [DATA_W-1:0] q;
      int                lat;
      iob_access(a, d, s, q, lat);
      check(lat, exp_lat, "write latency");
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] q,
                           input int exp_lat);
      int lat;
      iob_access(a, '0, '0, q, lat);
      check(lat, exp_lat, "read latency");
   endtask

   task automatic check_bank();
      logic [DATA_W-1:0] q;
      for (int i = 0; i < RF_DEPTH; i++) begin
         bus_read(rf_addr(i), q, 3);
         check(q, model[i], "register bank word");
      end
   endtask

   task automatic reset_state();
      check(32'(ready), 1, "iob_ready_o");
      check(32'(rvalid), 0, "iob_rvalid_o");
      check(32'(irq), 0, "irq_o");
      foreach (model[i]) model[i] = '0;
      check_bank();
   endtask

   task automatic full_word_rw();
      for (int i = 0; i < RF_DEPTH; i++) begin
         model[i] = $random(seed);
         bus_write(rf_addr(i), model[i], '1, 3);
      end
      check_bank();
   endtask

   task automatic byte_strobes();
      logic [STRB_W-1:0] pats [4] = '{4'b0001, 4'b0100, 4'b0011, 4'b1100};
      logic [DATA_W-1:0] d;
      logic [DATA_W-1:0] q;
      model[3] = $random(seed);
      bus_write(rf_addr(3), model[3], '1, 3);
      foreach (pats[p]) begin
         d        = $random(seed);
         model[3] = merge_bytes(model[3], d, pats[p]);
         bus_write(rf_addr(3), d, pats[p], 3);
         bus_read(rf_addr(3), q, 3);
         check(q, model[3], "strobed word");
      end
   endtask

   task automatic timer_count();
      logic [DATA_W-1:0] c0;
      logic [DATA_W-1:0] c1;
      bus_write(tmr_addr(TMR_COUNT_OFS), '0, '1, 4);
      bus_write(tmr_addr(TMR_CTRL_OFS), CTRL_EN, '1, 4);
      bus_read(tmr_addr(TMR_COUNT_OFS), c0, 4);
      bus_read(tmr_addr(TMR_COUNT_OFS), c1, 4);
      check(32'(c0 != 0), 1, "count running");
      check(32'(c1 > c0), 1, "count rising");
      bus_write(tmr_addr(TMR_CTRL_OFS), '0, '1, 4);
      bus_read(tmr_addr(TMR_COUNT_OFS), c0, 4);
      bus_read(tmr_addr(TMR_COUNT_OFS), c1, 4);
      check(c1, c0, "stopped count");
   endtask

   task automatic timer_irq();
      logic [DATA_W-1:0] c;
      int                n;
      // Drop the match left over from the count test
      bus_write(tmr_addr(TMR_STAT_OFS), 32'h1, '1, 4);
      bus_read(tmr_addr(TMR_STAT_OFS), c, 4);
      check(c, 0, "timer status before compare");
      bus_read(tmr_addr(TMR_COUNT_OFS), c, 4);  // Counter is stopped here
      bus_write(tmr_addr(TMR_CMP_OFS), c + 20, '1, 4);
      bus_write(tmr_addr(TMR_CTRL_OFS), CTRL_EN | CTRL_IRQEN, '1, 4);
      n = 0;
      while (!irq && n < 60) begin
         @(negedge clk);
         n++;
      end
      if (!irq) abort_run("Timer interrupt did not rise within 60 cycles");
      check(32'(n >= 20), 1, "interrupt before compare count");
      bus_read(tmr_addr(TMR_STAT_OFS), c, 4);
      check(c, 1, "timer status");
      bus_write(tmr_addr(TMR_STAT_OFS), 32'h1, '1, 4);
      @(negedge clk);  // irq_o trails the flag by a cycle
      check(32'(irq), 0, "irq_o after clear");
      bus_read(tmr_addr(TMR_STAT_OFS), c, 4);
      check(c, 0, "timer status after clear");
      // Second match with the interrupt masked
      bus_write(tmr_addr(TMR_CTRL_OFS), CTRL_EN, '1, 4);
      bus_read(tmr_addr(TMR_COUNT_OFS), c, 4);
      bus_write(tmr_addr(TMR_CMP_OFS), c + 20, '1, 4);
      repeat (40) begin
         @(negedge clk);
         check(32'(irq), 0, "masked irq_o");
      end
      bus_read(tmr_addr(TMR_STAT_OFS), c, 4);
      check(c, 1, "timer status while masked");
      bus_write(tmr_addr(TMR_CTRL_OFS), '0, '1, 4);
   endtask

   task automatic unmapped_access();
      logic [ADDR_W-1:0] holes [2] = '{12'h800, 12'hC00};
      logic [DATA_W-1:0] q;
      foreach (holes[h]) begin
         bus_write(holes[h], $random(seed), '1, 3);
         bus_read(holes[h], q, 3);
         check(q, 0, "unmapped read");
      end
      check_bank();  // Bank untouched by the hole writes
   endtask

   initial begin
      seed   = 94;
      reset  = 1'b1;
      avalid = 1'b0;
      addr   = '0;
      wdata  = '0;
      wstrb  = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      reset_state();
      full_word_rw();
      byte_strobes();
      timer_count();
      timer_irq();
      unmapped_access();
      run_closed = 1'b1;
      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      abort_run("Simulation timed out before all tests finished");
   end

   // A run stopped by a failing assertion
   final begin
      if (!run_closed) $display("SIMULATION FAILED");
   end

endmodule

`default_nettype wire

/* project.f */
hw/iob_apb_pkg.sv
hw/apb_if.sv
hw/iob2apb.sv
hw/apb_decoder.sv
hw/apb_regfile.sv
hw/apb_timer.sv
hw/iob_apb_top.sv
sim/iob_apb_props.sv
sim/tb_iob_apb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the IOb to APB testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_iob_apb -Mdir obj_dir -f project.f

./obj_dir/Vtb_iob_apb | tee "$LOG"

if grep -q "SIMULATION PASSED" "$LOG"; then
   echo "Result: pass"
   exit 0
else
   echo "Result: fail"
   exit 1
fi
